//--- verilog/ucpd_rx_defines.svh
/* USB PD receive path constants */
`ifndef UCPD_RX_DEFINES_SVH
`define UCPD_RX_DEFINES_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define UCPD_SYM_W   5          // One 4b5b line symbol
`define UCPD_NIB_W   4          // Decoded data nibble
`define UCPD_BYTE_W  8          // Assembled payload byte
`define UCPD_CNT_W   10         // Byte count, up to 1023 bytes
`define UCPD_KCODES  4          // K-codes per ordered set

// ----------------------------------------
// K-code symbols
// ----------------------------------------
// Written MSB first; bit 0 is the first bit on the line
`define UCPD_SYNC_1  5'b11000   // Startsynch #1
`define UCPD_SYNC_2  5'b10001   // Startsynch #2
`define UCPD_SYNC_3  5'b00110   // Startsynch #3
`define UCPD_RST_1   5'b00111   // Hard reset #1
`define UCPD_RST_2   5'b11001   // Hard reset #2
`define UCPD_EOP     5'b01101   // End of packet

`endif

//--- verilog/ucpd_rx_pkg.sv
/* USB PD receive types */
package ucpd_rx_pkg;

  // ----------------------------------------
  // Ordered set kind
  // ----------------------------------------
  typedef enum logic [2:0] {
    OS_SOP  = 3'd0,   // SOP
    OS_SOP1 = 3'd1,   // SOP'
    OS_SOP2 = 3'd2,   // SOP''
    OS_HRST = 3'd3,   // Hard Reset
    OS_CRST = 3'd4,   // Cable Reset
    OS_NONE = 3'd7    // No pattern reached three of four
  } ordset_kind_t;

  // ----------------------------------------
  // Receive phase
  // ----------------------------------------
  typedef enum logic [1:0] {
    PH_IDLE   = 2'd0, // Waiting for frame_start
    PH_ORDSET = 2'd1, // Collecting the four K-codes
    PH_DATA   = 2'd2  // Payload symbols until EOP
  } rx_phase_t;

endpackage

//--- verilog/ucpd_rx_symbol_shift.sv
/* Line bit to symbol shifter */
`timescale 1ns/100ps
`include "ucpd_rx_defines.svh"

module ucpd_rx_symbol_shift (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   bit_vld,      // One-cycle bit strobe
  input  logic                   bit_val,      // Decoded line bit
  input  logic                   frame_start,  // Next bit starts a symbol
  input  logic                   rx_idle,      // Receiver parked
  output logic                   sym_vld,      // Symbol strobe
  output logic [`UCPD_SYM_W-1:0] sym           // Completed symbol
);

  logic [`UCPD_SYM_W-1:0] shreg;               // Bits enter at the top
  logic [2:0]             bit_cnt;             // Bits held so far
  logic                   sym_done;

  assign sym_done = bit_vld && (bit_cnt == 3'(`UCPD_SYM_W - 1)); // Fifth bit arriving

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      bit_cnt <= '0;
      sym_vld <= 1'b0;
    end
    else
    begin
      sym_vld <= sym_done;
      if (frame_start || rx_idle)
        bit_cnt <= '0;                         // Realign on frame edge
      else if (sym_done)
        bit_cnt <= '0;
      else if (bit_vld)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  // First bit on the line ends up in bit 0
  always_ff @(posedge ucpd_clk)
  begin
    if (bit_vld)
      shreg <= {bit_val, shreg[`UCPD_SYM_W-1:1]};
    if (sym_done)
      sym <= {bit_val, shreg[`UCPD_SYM_W-1:1]};
  end

  // Bit strobes are spaced by at least one quiet cycle
  a_bit_gap: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    bit_vld |=> !bit_vld);

endmodule

//--- verilog/ucpd_rx_ordset_det.sv
/* Ordered set detector */
`timescale 1ns/100ps
`include "ucpd_rx_defines.svh"

module ucpd_rx_ordset_det
  import ucpd_rx_pkg::*;
(
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  rx_phase_t              phase,
  input  logic                   sym_vld,
  input  logic [`UCPD_SYM_W-1:0] sym,
  output logic                   ordset_vld,     // One pulse per ordered set
  output ordset_kind_t           ordset_kind,
  output logic [2:0]             ordset_bad_idx, // 0 clean, 1..4 bad K-code, 7 none
  output logic                   ordset_3of4     // Exactly one K-code corrupted
);

  localparam int KC    = `UCPD_KCODES;
  localparam int SYM_W = `UCPD_SYM_W;
  localparam int SET_W = KC * SYM_W;

  // First K-code in the low bits
  localparam logic [SET_W-1:0] PAT_SOP  = {`UCPD_SYNC_2, `UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_1};
  localparam logic [SET_W-1:0] PAT_SOP1 = {`UCPD_SYNC_3, `UCPD_SYNC_3, `UCPD_SYNC_1, `UCPD_SYNC_1};
  localparam logic [SET_W-1:0] PAT_SOP2 = {`UCPD_SYNC_3, `UCPD_SYNC_1, `UCPD_SYNC_3, `UCPD_SYNC_1};
  localparam logic [SET_W-1:0] PAT_HRST = {`UCPD_RST_2, `UCPD_RST_1, `UCPD_RST_1, `UCPD_RST_1};
  localparam logic [SET_W-1:0] PAT_CRST = {`UCPD_SYNC_3, `UCPD_RST_1, `UCPD_SYNC_1, `UCPD_RST_1};

  logic [SYM_W-1:0] kcode [KC-1];                // K-codes 1..3, the last one is live
  logic [1:0]       k_idx;                       // Position of the next K-code
  logic             take;
  logic             fire;                        // Last K-code on this cycle
  logic [SET_W-1:0] cur_set;
  logic [KC-1:0]    m_sop, m_sop1, m_sop2, m_hrst, m_crst;
  logic [KC-1:0]    m_sel;                       // Match vector of the winner
  ordset_kind_t     kind_nxt;
  logic [2:0]       bad_nxt;

  // Per-position compare of a received set against one pattern
  function automatic logic [KC-1:0] pos_match(input logic [SET_W-1:0] got,
                                               input logic [SET_W-1:0] pat);
    logic [KC-1:0] m;
    for (int i = 0; i < KC; i++)
      m[i] = (got[i*SYM_W +: SYM_W] == pat[i*SYM_W +: SYM_W]);
    return m;
  endfunction

  assign take = sym_vld && (phase == PH_ORDSET);
  assign fire = take && (k_idx == 2'(KC - 1));

  // ----------------------------------------
  // K-code capture
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      k_idx <= '0;
    else if (phase != PH_ORDSET)
      k_idx <= '0;                               // Restart for every frame
    else if (take)
      k_idx <= k_idx + 2'd1;                     // Wraps after the fourth
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (take && (k_idx != 2'(KC - 1)))
      kcode[k_idx] <= sym;
  end

  // ----------------------------------------
  // Three-of-four classification
  // ----------------------------------------
  always_comb
  begin
    cur_set[SET_W-1 -: SYM_W] = sym;
    for (int i = 0; i < KC - 1; i++)
      cur_set[i*SYM_W +: SYM_W] = kcode[i];
    m_sop  = pos_match(cur_set, PAT_SOP);
    m_sop1 = pos_match(cur_set, PAT_SOP1);
    m_sop2 = pos_match(cur_set, PAT_SOP2);
    m_hrst = pos_match(cur_set, PAT_HRST);
    m_crst = pos_match(cur_set, PAT_CRST);
    kind_nxt = OS_NONE;
    m_sel    = '0;
    if ($countones(m_hrst) >= 3)                 // Resets win over SOP kinds
    begin
      kind_nxt = OS_HRST;
      m_sel    = m_hrst;
    end
    else if ($countones(m_crst) >= 3)
    begin
      kind_nxt = OS_CRST;
      m_sel    = m_crst;
    end
    else if ($countones(m_sop) >= 3)
    begin
      kind_nxt = OS_SOP;
      m_sel    = m_sop;
    end
    else if ($countones(m_sop1) >= 3)
    begin
      kind_nxt = OS_SOP1;
      m_sel    = m_sop1;
    end
    else if ($countones(m_sop2) >= 3)
    begin
      kind_nxt = OS_SOP2;
      m_sel    = m_sop2;
    end
    case (m_sel)
      4'b1111: bad_nxt = 3'd0;                   // All K-codes good
      4'b1110: bad_nxt = 3'd1;
      4'b1101: bad_nxt = 3'd2;
      4'b1011: bad_nxt = 3'd3;
      4'b0111: bad_nxt = 3'd4;
      default: bad_nxt = 3'd7;                   // Nothing matched
    endcase
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      ordset_vld     <= 1'b0;
      ordset_kind    <= OS_NONE;
      ordset_bad_idx <= 3'd0;
      ordset_3of4    <= 1'b0;
    end
    else
    begin
      ordset_vld <= fire;
      if (fire)
      begin
        ordset_kind    <= kind_nxt;
        ordset_bad_idx <= bad_nxt;
        ordset_3of4    <= ($countones(m_sel) == 3);
      end
    end
  end

  // The phase controller holds ordset until it has seen the result
  a_vld_in_ordset: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    ordset_vld |-> (phase == PH_ORDSET));

endmodule

//--- verilog/ucpd_rx_phase_ctrl.sv
/* Receive phase controller */
`timescale 1ns/100ps
`include "ucpd_rx_defines.svh"

module ucpd_rx_phase_ctrl
  import ucpd_rx_pkg::*;
(
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   frame_start,  // Preamble done
  input  logic                   rx_idle,      // Abort to idle
  input  logic                   sym_vld,
  input  logic [`UCPD_SYM_W-1:0] sym,
  input  logic                   ordset_vld,
  input  ordset_kind_t           ordset_kind,
  output rx_phase_t              phase,
  output logic                   msg_end       // EOP seen in the payload
);

  logic is_sop;                                // Ordered set opens a message
  logic eop_hit;

  assign is_sop  = (ordset_kind == OS_SOP) || (ordset_kind == OS_SOP1) ||
                   (ordset_kind == OS_SOP2);
  assign eop_hit = (phase == PH_DATA) && sym_vld && (sym == `UCPD_EOP) && !rx_idle;

  // ----------------------------------------
  // Phase FSM
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      phase <= PH_IDLE;
    else if (rx_idle)
      phase <= PH_IDLE;
    else
    begin
      case (phase)
        PH_IDLE:
          if (frame_start)
            phase <= PH_ORDSET;
        PH_ORDSET:
          if (ordset_vld)
            phase <= is_sop ? PH_DATA : PH_IDLE; // Resets and junk carry no payload
        PH_DATA:
          if (eop_hit)
            phase <= PH_IDLE;
        default:
          phase <= PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      msg_end <= 1'b0;
    else
      msg_end <= eop_hit;
  end

endmodule

//--- verilog/ucpd_rx_byte_asm.sv
/* Payload byte assembler */
`timescale 1ns/100ps
`include "ucpd_rx_defines.svh"

module ucpd_rx_byte_asm
  import ucpd_rx_pkg::*;
(
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  rx_phase_t               phase,
  input  logic                    frame_start,
  input  logic                    rx_idle,
  input  logic                    sym_vld,
  input  logic [`UCPD_SYM_W-1:0]  sym,
  input  logic                    byte_rdy,
  output logic                    byte_vld,
  output logic [`UCPD_BYTE_W-1:0] byte_data,
  output logic                    rx_ovrflow,   // Untaken byte overwritten
  output logic [`UCPD_CNT_W-1:0]  byte_cnt      // Bytes in this message
);

  logic [`UCPD_NIB_W-1:0] nib;                  // Decoded current symbol
  logic [`UCPD_NIB_W-1:0] lo_nib;               // Held low half
  logic                   hi_pend;              // Low half waiting for its pair
  logic                   data_stb;
  logic                   byte_done;            // Second nibble on this cycle

  // 4b5b data table, anything else reads as zero
  function automatic logic [`UCPD_NIB_W-1:0] dec_4b5b(input logic [`UCPD_SYM_W-1:0] s);
    case (s)
      5'b11110: return 4'h0;
      5'b01001: return 4'h1;
      5'b10100: return 4'h2;
      5'b10101: return 4'h3;
      5'b01010: return 4'h4;
      5'b01011: return 4'h5;
      5'b01110: return 4'h6;
      5'b01111: return 4'h7;
      5'b10010: return 4'h8;
      5'b10011: return 4'h9;
      5'b10110: return 4'hA;
      5'b10111: return 4'hB;
      5'b11010: return 4'hC;
      5'b11011: return 4'hD;
      5'b11100: return 4'hE;
      5'b11101: return 4'hF;
      default:  return 4'h0;                    // K-codes and bad codes
    endcase
  endfunction

  assign nib       = dec_4b5b(sym);
  assign data_stb  = sym_vld && (phase == PH_DATA) && !rx_idle;
  assign byte_done = data_stb && hi_pend;

  // ----------------------------------------
  // Nibble pairing
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      hi_pend <= 1'b0;
    else if (rx_idle || frame_start || (phase != PH_DATA))
      hi_pend <= 1'b0;                          // Odd nibble is dropped
    else if (data_stb)
      hi_pend <= !hi_pend;
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (data_stb && !hi_pend)
      lo_nib <= nib;                            // First nibble is the low half
    if (byte_done)
      byte_data <= {nib, lo_nib};
  end

  // ----------------------------------------
  // Output handshake and count
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      byte_vld   <= 1'b0;
      rx_ovrflow <= 1'b0;
      byte_cnt   <= '0;
    end
    else
    begin
      rx_ovrflow <= byte_done && byte_vld && !byte_rdy;
      if (byte_done)
        byte_vld <= 1'b1;                       // New byte replaces any held one
      else if (byte_rdy)
        byte_vld <= 1'b0;
      if (frame_start || rx_idle)
        byte_cnt <= '0;
      else if (byte_done)
        byte_cnt <= byte_cnt + 1'b1;
    end
  end

  // Held byte stays put until taken, unless overrun
  a_hold_stable: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (byte_vld && !byte_rdy) |=> byte_vld && ($stable(byte_data) || rx_ovrflow));

endmodule

//--- verilog/ucpd_rx_top.sv
/* USB PD receive path top */
`timescale 1ns/100ps

module ucpd_rx_top
  import ucpd_rx_pkg::*;
(
  input  logic         ucpd_clk,
  input  logic         ic_rst_n,
  input  logic         bit_vld,        // Decoded bit strobe
  input  logic         bit_val,
  input  logic         frame_start,    // End of preamble
  input  logic         rx_idle,        // Abort and park
  input  logic         byte_rdy,
  output logic         ordset_vld,
  output ordset_kind_t ordset_kind,
  output logic [2:0]   ordset_bad_idx,
  output logic         ordset_3of4,
  output logic         byte_vld,
  output logic [7:0]   byte_data,
  output logic         rx_ovrflow,
  output logic [9:0]   byte_cnt,
  output logic         msg_end
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------
  logic       sym_vld;                 // Symbol strobe to all consumers
  logic [4:0] sym;
  rx_phase_t  phase;

  ucpd_rx_symbol_shift u_shift (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .bit_vld    (bit_vld),
    .bit_val    (bit_val),
    .frame_start(frame_start),
    .rx_idle    (rx_idle),
    .sym_vld    (sym_vld),
    .sym        (sym)
  );

  ucpd_rx_ordset_det u_ordset (
    .ucpd_clk      (ucpd_clk),
    .ic_rst_n      (ic_rst_n),
    .phase         (phase),
    .sym_vld       (sym_vld),
    .sym           (sym),
    .ordset_vld    (ordset_vld),
    .ordset_kind   (ordset_kind),
    .ordset_bad_idx(ordset_bad_idx),
    .ordset_3of4   (ordset_3of4)
  );

  ucpd_rx_phase_ctrl u_phase (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .frame_start(frame_start),
    .rx_idle    (rx_idle),
    .sym_vld    (sym_vld),
    .sym        (sym),
    .ordset_vld (ordset_vld),
    .ordset_kind(ordset_kind),
    .phase      (phase),
    .msg_end    (msg_end)
  );

  ucpd_rx_byte_asm u_bytes (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .phase      (phase),
    .frame_start(frame_start),
    .rx_idle    (rx_idle),
    .sym_vld    (sym_vld),
    .sym        (sym),
    .byte_rdy   (byte_rdy),
    .byte_vld   (byte_vld),
    .byte_data  (byte_data),
    .rx_ovrflow (rx_ovrflow),
    .byte_cnt   (byte_cnt)
  );

endmodule

//--- tests/tb_ucpd_rx.sv
/* USB PD receive path testbench */
`timescale 1ns/100ps
`include "ucpd_rx_defines.svh"

module tb_ucpd_rx
  import ucpd_rx_pkg::*;
();

  localparam int TOTAL_SYMBOLS = 17 + 35 + 14 + 9 + 30;       // Per test, in run order
  localparam int TOTAL_BITS    = TOTAL_SYMBOLS * `UCPD_SYM_W;
  localparam logic [4:0] NOT_K = 5'b11110;                    // Data 0, never a K-code

  logic         ucpd_clk = 1'b0;
  logic         ic_rst_n;
  logic         bit_vld;
  logic         bit_val;
  logic         frame_start;
  logic         rx_idle;
  logic         byte_rdy;
  logic         ordset_vld;
  ordset_kind_t ordset_kind;
  logic [2:0]   ordset_bad_idx;
  logic         ordset_3of4;
  logic         byte_vld;
  logic [7:0]   byte_data;
  logic         rx_ovrflow;
  logic [9:0]   byte_cnt;
  logic         msg_end;

  int          mismatches = 0;
  int          failures = 0;
  int          ovf_n;                                         // rx_ovrflow pulses seen
  logic [31:0] lfsr = 32'd72014;
  logic [7:0]  exp_bytes [$];
  logic [7:0]  got_bytes [$];                                 // Transfers on the port
  logic [2:0]  os_kinds [$];
  logic [2:0]  os_bad [$];
  logic        os_3of4 [$];
  logic [9:0]  end_cnts [$];                                  // byte_cnt at each msg_end

  always #2 ucpd_clk = ~ucpd_clk;                             // 4 ns period

  ucpd_rx_top uut (
    .ucpd_clk      (ucpd_clk),
    .ic_rst_n      (ic_rst_n),
    .bit_vld       (bit_vld),
    .bit_val       (bit_val),
    .frame_start   (frame_start),
    .rx_idle       (rx_idle),
    .byte_rdy      (byte_rdy),
    .ordset_vld    (ordset_vld),
    .ordset_kind   (ordset_kind),
    .ordset_bad_idx(ordset_bad_idx),
    .ordset_3of4   (ordset_3of4),
    .byte_vld      (byte_vld),
    .byte_data     (byte_data),
    .rx_ovrflow    (rx_ovrflow),
    .byte_cnt      (byte_cnt),
    .msg_end       (msg_end)
  );

  // ----------------------------------------
  // Monitor, mid-cycle so outputs are settled
  // ----------------------------------------
  always @(negedge ucpd_clk)
  begin
    if (ic_rst_n)
    begin
      if (byte_vld && byte_rdy)
        got_bytes.push_back(byte_data);
      if (ordset_vld)
      begin
        os_kinds.push_back(ordset_kind);
        os_bad.push_back(ordset_bad_idx);
        os_3of4.push_back(ordset_3of4);
      end
      if (msg_end)
        end_cnts.push_back(byte_cnt);
      if (rx_ovrflow)
        ovf_n++;
    end
  end

  // Bit time is 3 cycles, plus slack for reset and gaps
  initial
  begin
    #(TOTAL_BITS * 3 * 4 + 2000);
    $display("Timeout: the tests did not finish within %0d ns", TOTAL_BITS * 12 + 2000);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};           // x^32+x^22+x^2+x+1
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);                                 // One step per bit
      b[i] = lfsr[0];
    end
  endtask

  // 4b5b line code, bit 0 goes out first
  function automatic logic [4:0] encode_nibble(input logic [3:0] n);
    case (n)
      4'h0: return 5'b11110;
      4'h1: return 5'b01001;
      4'h2: return 5'b10100;
      4'h3: return 5'b10101;
      4'h4: return 5'b01010;
      4'h5: return 5'b01011;
      4'h6: return 5'b01110;
      4'h7: return 5'b01111;
      4'h8: return 5'b10010;
      4'h9: return 5'b10011;
      4'hA: return 5'b10110;
      4'hB: return 5'b10111;
      4'hC: return 5'b11010;
      4'hD: return 5'b11011;
      4'hE: return 5'b11100;
      default: return 5'b11101;
    endcase
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge ucpd_clk);
  endtask

  task automatic drive_bit(input logic b);
    @(posedge ucpd_clk);
    bit_vld <= 1'b1;
    bit_val <= b;
    @(posedge ucpd_clk);
    bit_vld <= 1'b0;
    @(posedge ucpd_clk);                                      // Strobe every 3 cycles
  endtask

  task automatic send_symbol(input logic [4:0] s);
    for (int i = 0; i < 5; i++)
      drive_bit(s[i]);
  endtask

  task automatic send_byte(input logic [7:0] b);
    send_symbol(encode_nibble(b[3:0]));                       // Low half first
    send_symbol(encode_nibble(b[7:4]));
  endtask

  task automatic start_frame(input logic [4:0] k1, input logic [4:0] k2,
                             input logic [4:0] k3, input logic [4:0] k4);
    @(posedge ucpd_clk);
    frame_start <= 1'b1;
    @(posedge ucpd_clk);
    frame_start <= 1'b0;
    send_symbol(k1);
    send_symbol(k2);
    send_symbol(k3);
    send_symbol(k4);
  endtask

  task automatic send_payload(input int n, input bit keep);
    logic [7:0] b;
    for (int i = 0; i < n; i++)
    begin
      next_rand_byte(b);
      if (keep)
        exp_bytes.push_back(b);
      send_byte(b);
    end
  endtask

  task automatic clear_monitor();
    exp_bytes.delete();
    got_bytes.delete();
    os_kinds.delete();
    os_bad.delete();
    os_3of4.delete();
    end_cnts.delete();
    ovf_n = 0;
  endtask

  task automatic wait_msg_end();
    int n;
    n = 0;
    while (end_cnts.size() == 0 && n < 40)
    begin
      @(posedge ucpd_clk);
      n++;
    end
    assert (end_cnts.size() != 0) else
    begin
      failures++;
      $display("ERROR: msg_end did not arrive after EOP");
    end
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
    begin
      mismatches++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else
    begin
      failures++;
      $display("ERROR: %s", what);
    end
  endtask

  task automatic check_ordset(input logic [2:0] kind, input logic [2:0] bad, input logic tof);
    check_true(os_kinds.size() == 1, "expected exactly one ordset_vld pulse");
    if (os_kinds.size() > 0)
    begin
      check_val("ordset_kind", os_kinds[0], kind);
      check_val("ordset_bad_idx", os_bad[0], bad);
      check_val("ordset_3of4", os_3of4[0], tof);
    end
  endtask

  task automatic check_bytes();
    check_true(got_bytes.size() == exp_bytes.size(), "wrong number of bytes transferred");
    for (int i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++)
      check_val("byte_data", got_bytes[i], exp_bytes[i]);
  endtask

  task automatic check_end(input int n);
    check_true(end_cnts.size() == 1, "expected exactly one msg_end pulse");
    if (end_cnts.size() > 0)
      check_val("byte_cnt", end_cnts[0], n);
  endtask

  task automatic check_silent();
    check_true(got_bytes.size() == 0, "bytes came out after a non-SOP ordered set");
    check_true(end_cnts.size() == 0, "msg_end came after a non-SOP ordered set");
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic clean_sop_message(input int n);
    clear_monitor();
    start_frame(`UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_2);
    send_payload(n, 1'b1);
    send_symbol(`UCPD_EOP);
    wait_msg_end();
    idle_cycles(4);
    check_ordset(OS_SOP, 3'd0, 1'b0);
    check_bytes();
    check_end(n);
    check_true(ovf_n == 0, "rx_ovrflow pulsed with byte_rdy high");
  endtask

  task automatic three_of_four_sets();
    logic [4:0] k [4];
    for (int pos = 1; pos <= 4; pos++)
    begin
      k = '{`UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_3, `UCPD_SYNC_3};
      k[pos-1] = NOT_K;                                       // One bad K-code
      clear_monitor();
      start_frame(k[0], k[1], k[2], k[3]);
      send_payload(1, 1'b1);
      send_symbol(`UCPD_EOP);
      wait_msg_end();
      idle_cycles(4);
      check_ordset(OS_SOP1, 3'(pos), 1'b1);
      check_bytes();
      check_end(1);
    end
    clear_monitor();
    start_frame(NOT_K, NOT_K, `UCPD_SYNC_1, `UCPD_SYNC_3);    // SOP'' with two bad
    send_payload(1, 1'b0);
    send_symbol(`UCPD_EOP);
    idle_cycles(8);
    check_ordset(OS_NONE, 3'd7, 1'b0);
    check_silent();
  endtask

  task automatic reset_ordered_sets();
    clear_monitor();
    start_frame(`UCPD_RST_1, `UCPD_RST_1, `UCPD_RST_1, `UCPD_RST_2);
    send_payload(1, 1'b0);
    send_symbol(`UCPD_EOP);
    idle_cycles(8);
    check_ordset(OS_HRST, 3'd0, 1'b0);
    check_silent();
    clear_monitor();
    start_frame(`UCPD_RST_1, `UCPD_SYNC_1, `UCPD_RST_1, `UCPD_SYNC_3);
    send_payload(1, 1'b0);
    send_symbol(`UCPD_EOP);
    idle_cycles(8);
    check_ordset(OS_CRST, 3'd0, 1'b0);
    check_silent();
  endtask

  task automatic back_pressure();
    int n;
    clear_monitor();
    @(posedge ucpd_clk);
    byte_rdy <= 1'b0;
    start_frame(`UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_2);
    send_payload(2, 1'b1);
    void'(exp_bytes.pop_front());                             // First byte gets overwritten
    send_symbol(`UCPD_EOP);
    wait_msg_end();
    idle_cycles(4);
    @(negedge ucpd_clk);
    check_val("byte_vld", byte_vld, 1);                       // Second byte still offered
    check_val("byte_data", byte_data, exp_bytes[0]);
    check_true(ovf_n == 1, "expected exactly one rx_ovrflow pulse");
    check_end(2);
    @(posedge ucpd_clk);
    byte_rdy <= 1'b1;
    n = 0;
    while (got_bytes.size() == 0 && n < 20)
    begin
      @(posedge ucpd_clk);
      n++;
    end
    idle_cycles(4);
    check_ordset(OS_SOP, 3'd0, 1'b0);
    check_bytes();
  endtask

  task automatic abort_message();
    logic [7:0] b;
    clear_monitor();
    start_frame(`UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_1, `UCPD_SYNC_2);
    send_payload(3, 1'b1);
    next_rand_byte(b);
    send_symbol(encode_nibble(b[3:0]));                       // Half byte left hanging
    @(posedge ucpd_clk);
    rx_idle <= 1'b1;
    idle_cycles(2);
    rx_idle <= 1'b0;
    @(negedge ucpd_clk);
    check_val("byte_cnt", byte_cnt, 0);
    send_symbol(encode_nibble(b[7:4]));
    send_symbol(`UCPD_EOP);
    idle_cycles(8);
    check_bytes();
    check_true(end_cnts.size() == 0, "msg_end came for an aborted message");
    clean_sop_message(6);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    ic_rst_n    <= 1'b0;
    bit_vld     <= 1'b0;
    bit_val     <= 1'b0;
    frame_start <= 1'b0;
    rx_idle     <= 1'b0;
    byte_rdy    <= 1'b1;
    repeat (5) @(posedge ucpd_clk);
    ic_rst_n <= 1'b1;
    @(negedge ucpd_clk);
    check_true(!ordset_vld && !byte_vld && !msg_end && !rx_ovrflow,
               "outputs not low after reset");
    idle_cycles(2);
    clean_sop_message(6);
    three_of_four_sets();
    reset_ordered_sets();
    back_pressure();
    abort_message();
    idle_cycles(4);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+verilog
verilog/ucpd_rx_pkg.sv
verilog/ucpd_rx_symbol_shift.sv
verilog/ucpd_rx_ordset_det.sv
verilog/ucpd_rx_phase_ctrl.sv
verilog/ucpd_rx_byte_asm.sv
verilog/ucpd_rx_top.sv
tests/tb_ucpd_rx.sv
